// File: hdl/divmmc_pkg.sv
`default_nettype none

package divmmc_pkg;

    // z80 bus as presented by the machine
    typedef struct packed {
        logic [15:0] a;         // live address
        logic [15:0] a_reg;     // address latched for the cycle
        logic [7:0]  d_reg;     // data latched for the cycle
        logic        m1;
        logic        memreq;
        logic        ioreq;
        logic        rd;
        logic        wr;
    } cpu_bus_t;

    // port e3 state seen by the mapper
    typedef struct packed {
        logic [3:0] page;       // ram bank at 2000-3fff
        logic       conmem;
        logic       mapram;     // sticky until reset
    } divmmc_ctrl_t;

    // divmmc ports
    localparam logic [7:0] port_e3 = 8'hE3;    // control
    localparam logic [7:0] port_e7 = 8'hE7;    // card select
    localparam logic [7:0] port_eb = 8'hEB;    // spi data

    // zx-mmc ports
    localparam logic [7:0] port_57 = 8'h57;    // spi data
    localparam logic [7:0] port_77 = 8'h77;    // select and card detect

    // rom entry points that trigger automap
    localparam logic [15:0] addr_rst0      = 16'h0000;
    localparam logic [15:0] addr_rst8      = 16'h0008;  // error restart
    localparam logic [15:0] addr_rst38     = 16'h0038;  // im1 handler
    localparam logic [15:0] addr_nmi       = 16'h0066;
    localparam logic [15:0] addr_tape_save = 16'h04C6;
    localparam logic [15:0] addr_tape_load = 16'h0562;

endpackage

`default_nettype wire

// File: hdl/divmmc_automap.sv
`timescale 1ns/10ps
`default_nettype none

module divmmc_automap #(
    parameter logic [7:0] trdos_page = 8'h3D
) (
    input  logic                 clk28,
    input  logic                 rst_n,
    input  logic                 en,
    input  logic                 en_hooks,
    input  logic                 rammap,
    input  logic                 magic_mode,
    input  logic                 magic_map,
    input  divmmc_pkg::cpu_bus_t bus,
    output logic                 automap
);
    import divmmc_pkg::*;

    logic fetch;
    logic hooks_off;
    logic hook_hit;
    logic exit_hit;
    logic trdos_hit;
    logic automap_next;

    assign fetch     = bus.m1 && bus.memreq && !magic_map;
    assign hooks_off = !en || !en_hooks || rammap;

    assign hook_hit = bus.a_reg == addr_rst0 ||
                      bus.a_reg == addr_rst8 ||
                      bus.a_reg == addr_rst38 ||
                      (bus.a_reg == addr_nmi && !magic_mode) ||   // nmi owned by magic rom
                      bus.a_reg == addr_tape_save ||
                      bus.a_reg == addr_tape_load;

    assign exit_hit  = bus.a_reg[15:3] == 13'h03FF;     // 1ff8-1fff
    assign trdos_hit = bus.a_reg[15:8] == trdos_page;

    // pending state tracks the fetch, automap takes it once m1 drops
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            automap_next <= 1'b0;
            automap      <= 1'b0;
        end else if (fetch) begin
            if (hooks_off) begin
                automap_next <= 1'b0;
            end else if (exit_hit) begin
                automap_next <= 1'b0;
            end else if (hook_hit) begin
                automap_next <= 1'b1;
            end else if (trdos_hit) begin
                automap_next <= 1'b1;
                automap      <= 1'b1;   // no delay here
            end
        end else if (!bus.m1) begin
            automap <= automap_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/divmmc_ports.sv
`timescale 1ns/10ps
`default_nettype none

module divmmc_ports (
    input  logic                     clk28,
    input  logic                     rst_n,
    input  logic                     ck14,
    input  logic                     ck7,
    input  logic                     en,
    input  logic                     en_zc,
    input  logic                     sd_cd,
    input  logic                     sd_miso,
    input  divmmc_pkg::cpu_bus_t     bus,
    output divmmc_pkg::divmmc_ctrl_t ctrl,
    output logic                     sd_mosi,
    output logic                     sd_sck,
    output logic                     sd_cs,
    output logic                     cpuwait,
    output logic                     d_out_active,
    output logic [7:0]               d_out
);
    import divmmc_pkg::*;

    localparam logic [3:0] spi_start = 4'b1110;    // two lead-in steps
    localparam logic [3:0] spi_idle  = 4'b1000;

    logic       e3_cs;
    logic       e7_cs;
    logic       eb_cs;
    logic       zc57_cs;
    logic       zc77_cs;
    logic       spi_cs;
    logic       spi_acc;
    logic       spi_acc_q;
    logic       spi_go;
    logic       spi_busy;
    logic [3:0] spi_cnt;
    logic [7:0] spi_reg;
    logic       mosi_en;
    logic       sck_q;
    logic       spi_rd;
    logic       zc_rd;

    assign e3_cs   = en && bus.ioreq && bus.a_reg[7:0] == port_e3;
    assign e7_cs   = en && bus.ioreq && bus.a_reg[7:0] == port_e7;
    assign eb_cs   = en && bus.ioreq && bus.a_reg[7:0] == port_eb;
    assign zc57_cs = en_zc && bus.ioreq && bus.a_reg[7:0] == port_57;
    assign zc77_cs = en_zc && bus.ioreq && bus.a_reg[7:0] == port_77;

    assign spi_cs   = eb_cs || zc57_cs;
    assign spi_acc  = spi_cs && (bus.rd || bus.wr);
    assign spi_go   = spi_acc && !spi_acc_q;       // first cycle of the access
    assign spi_busy = spi_cnt != spi_idle;
    assign cpuwait  = spi_busy;

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            ctrl  <= '0;
            sd_cs <= 1'b1;
        end else begin
            if (e3_cs && bus.wr) begin
                ctrl.page   <= bus.d_reg[3:0];
                ctrl.conmem <= bus.d_reg[7];
                ctrl.mapram <= ctrl.mapram | bus.d_reg[6];  // set only
            end
            if (e7_cs && bus.wr) begin
                sd_cs <= bus.d_reg[0];
            end else if (zc77_cs && bus.wr) begin
                sd_cs <= bus.d_reg[1] | ~bus.d_reg[0];
            end
        end
    end

    // 0xxx shifts, 1110/1111 lead in, 1000 idle
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            spi_acc_q <= 1'b0;
            spi_cnt   <= 4'd0;      // init clocks after reset
            mosi_en   <= 1'b0;
        end else begin
            spi_acc_q <= spi_acc;
            if (spi_go) begin
                spi_cnt <= spi_start;
            end else if (spi_busy && ck7) begin
                spi_cnt <= spi_cnt + 4'd1;
            end
            if (spi_go && bus.wr) begin
                mosi_en <= 1'b1;
            end else if (!spi_busy) begin
                mosi_en <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk28) begin
        if (spi_go && bus.wr) begin
            spi_reg <= bus.d_reg;
        end else if (!spi_cnt[3] && ck7) begin
            spi_reg <= {spi_reg[6:0], sd_miso};
        end
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            sck_q <= 1'b0;
        end else if (spi_cnt[3]) begin
            sck_q <= 1'b0;
        end else if (ck14) begin
            sck_q <= ~sck_q;
        end
    end

    assign sd_sck  = sck_q & ~spi_cnt[3];
    assign sd_mosi = (mosi_en && spi_busy) ? spi_reg[7] : 1'b1;

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            spi_rd <= 1'b0;
            zc_rd  <= 1'b0;
        end else begin
            spi_rd <= spi_cs && bus.rd;
            zc_rd  <= zc77_cs && bus.rd;
        end
    end

    assign d_out_active = spi_rd | zc_rd;
    assign d_out        = zc_rd ? {7'd0, sd_cd} : spi_reg;

endmodule

`default_nettype wire

// File: hdl/divmmc_memmap.sv
`timescale 1ns/10ps
`default_nettype none

module divmmc_memmap (
    input  logic                     automap,
    input  divmmc_pkg::divmmc_ctrl_t ctrl,
    input  logic [15:0]              a,
    output logic                     map,
    output logic                     ram,
    output logic                     ramwr_mask
);

    logic lower_16k;
    logic page3;
    logic mapram_auto;

    assign lower_16k   = a[15:14] == 2'b00;
    assign page3       = ctrl.page == 4'd3;
    assign mapram_auto = automap && ctrl.mapram && !ctrl.conmem;

    assign map = automap | ctrl.conmem;

    // ram bank at 2000-3fff, or page 3 in place of the rom
    assign ram = ((automap || ctrl.conmem) && a[13]) || mapram_auto;

    // page 3 acts as rom under mapram
    assign ramwr_mask = lower_16k && (!a[13] || page3) && mapram_auto;

endmodule

`default_nettype wire

// File: hdl/divmmc_top.sv
`timescale 1ns/10ps
`default_nettype none

module divmmc_top #(
    parameter logic [7:0] trdos_page = 8'h3D
) (
    input  divmmc_pkg::cpu_bus_t bus,
    input  logic                 clk28,
    input  logic                 rst_n,
    input  logic                 ck14,
    input  logic                 ck7,
    input  logic                 en,
    input  logic                 en_hooks,
    input  logic                 en_zc,
    input  logic                 sd_cd,
    input  logic                 sd_miso,
    input  logic                 rammap,
    input  logic                 magic_mode,
    input  logic                 magic_map,
    output logic [7:0]           d_out,
    output logic                 d_out_active,
    output logic                 sd_mosi,
    output logic                 sd_sck,
    output logic                 sd_cs,
    output logic [3:0]           page,
    output logic                 map,
    output logic                 automap,
    output logic                 ram,
    output logic                 ramwr_mask,
    output logic                 cpuwait
);
    import divmmc_pkg::*;

    divmmc_ctrl_t ctrl;

    assign page = ctrl.page;

    divmmc_automap #(
        .trdos_page (trdos_page)
    ) divmmc_automap_inst (
        .clk28      (clk28),
        .rst_n      (rst_n),
        .en         (en),
        .en_hooks   (en_hooks),
        .rammap     (rammap),
        .magic_mode (magic_mode),
        .magic_map  (magic_map),
        .bus        (bus),
        .automap    (automap)
    );

    divmmc_ports divmmc_ports_inst (
        .clk28        (clk28),
        .rst_n        (rst_n),
        .ck14         (ck14),
        .ck7          (ck7),
        .en           (en),
        .en_zc        (en_zc),
        .sd_cd        (sd_cd),
        .sd_miso      (sd_miso),
        .bus          (bus),
        .ctrl         (ctrl),
        .sd_mosi      (sd_mosi),
        .sd_sck       (sd_sck),
        .sd_cs        (sd_cs),
        .cpuwait      (cpuwait),
        .d_out_active (d_out_active),
        .d_out        (d_out)
    );

    divmmc_memmap divmmc_memmap_inst (
        .automap    (automap),
        .ctrl       (ctrl),
        .a          (bus.a),      // live address, not the latched one
        .map        (map),
        .ram        (ram),
        .ramwr_mask (ramwr_mask)
    );

endmodule

`default_nettype wire

// File: sim/divmmc_chk.sv
`timescale 1ns/10ps
`default_nettype none

module divmmc_chk (
    input logic                 clk28,
    input logic                 rst_n,
    input logic                 en,
    input logic                 en_zc,
    input divmmc_pkg::cpu_bus_t bus,
    input logic                 map,
    input logic                 ram,
    input logic                 ramwr_mask,
    input logic                 d_out_active,
    input logic                 sd_mosi,
    input logic                 sd_sck,
    input logic                 cpuwait
);
    import divmmc_pkg::*;

    int   fail_count = 0;
    logic port_read;

    assign port_read = bus.ioreq && bus.rd &&
                       ((en && bus.a_reg[7:0] == port_eb) ||
                        (en_zc && (bus.a_reg[7:0] == port_57 || bus.a_reg[7:0] == port_77)));

    ram_in_map: assert property (@(posedge clk28) disable iff (!rst_n) ram |-> map)
        else begin
            $error("ram selected while map is low");
            fail_count++;
        end

    mask_in_ram: assert property (@(posedge clk28) disable iff (!rst_n) ramwr_mask |-> ram)
        else begin
            $error("write protect set outside divmmc ram");
            fail_count++;
        end

    read_data_valid: assert property (@(posedge clk28) disable iff (!rst_n)
        d_out_active |-> $past(port_read))
        else begin
            $error("d_out_active high without a port read on the previous cycle");
            fail_count++;
        end

    mosi_idle: assert property (@(posedge clk28) disable iff (!rst_n) !cpuwait |-> sd_mosi)
        else begin
            $error("sd_mosi low while spi is idle");
            fail_count++;
        end

    sck_idle: assert property (@(posedge clk28) disable iff (!rst_n) !cpuwait |-> !sd_sck)
        else begin
            $error("sd_sck high while spi is idle");
            fail_count++;
        end

endmodule

bind divmmc_top divmmc_chk divmmc_chk_inst (
    .clk28        (clk28),
    .rst_n        (rst_n),
    .en           (en),
    .en_zc        (en_zc),
    .bus          (bus),
    .map          (map),
    .ram          (ram),
    .ramwr_mask   (ramwr_mask),
    .d_out_active (d_out_active),
    .sd_mosi      (sd_mosi),
    .sd_sck       (sd_sck),
    .cpuwait      (cpuwait)
);

`default_nettype wire

// File: sim/divmmc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module divmmc_tb;
    import divmmc_pkg::*;

    localparam int wait_limit = 200;

    logic       clk28 = 1'b0;
    logic       rst_n;
    logic       en;
    logic       en_hooks;
    logic       en_zc;
    logic       sd_cd;
    logic       rammap;
    logic       magic_mode;
    logic       magic_map;
    logic       ck14 = 1'b0;
    logic       ck7 = 1'b0;
    logic       sd_miso = 1'b1;
    logic [1:0] div = 2'd0;
    cpu_bus_t   bus;
    logic [7:0] d_out;
    logic [3:0] page;
    logic       d_out_active;
    logic       sd_mosi;
    logic       sd_sck;
    logic       sd_cs;
    logic       map;
    logic       automap;
    logic       ram;
    logic       ramwr_mask;
    logic       cpuwait;

    integer     seed = 93895;
    int         errors = 0;
    int         checks = 0;
    int         timeouts = 0;
    logic [7:0] tx_byte = 8'hFF;    // card to host
    logic [7:0] rx_byte = 8'h00;    // last eight bits sent to the card
    logic [7:0] wr_byte;
    int         bit_idx = 0;
    logic       sck_seen = 1'b0;
    logic [7:0] rdata;
    logic       active;
    logic       saw_wait;
    logic [7:0] sel_data [6] = '{8'h00, 8'h01, 8'h02, 8'h01, 8'h03, 8'h01};
    logic       sel_cs [6] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};   // select after each write

    divmmc_top #(.trdos_page(8'h3D)) divmmc_top_inst (.*);

    initial begin
        forever #10 clk28 = ~clk28;
    end

    // ck7 pulses with every second ck14
    always @(posedge clk28) begin
        #2;
        div = div + 2'd1;
        ck14 = div[0];
        ck7 = div == 2'd3;
    end

    // sd card model captures on sck rise and moves on after the fall
    always @(posedge clk28) begin
        #2;
        if (!cpuwait) begin
            bit_idx = 0;
        end else if (sd_sck && !sck_seen) begin
            rx_byte = {rx_byte[6:0], sd_mosi};
        end else if (!sd_sck && sck_seen && bit_idx < 7) begin
            bit_idx = bit_idx + 1;
        end
        sck_seen = sd_sck;
        sd_miso = tx_byte[7 - bit_idx];
    end

    task automatic next_cycle();
        @(posedge clk28);
        #2;
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic run_fetch(input logic [15:0] addr, input logic during, input logic after);
        bus.a = addr;
        bus.a_reg = addr;
        bus.m1 = 1'b1;
        bus.memreq = 1'b1;
        repeat (2) next_cycle();
        check_value("automap", automap, during);
        bus.m1 = 1'b0;
        bus.memreq = 1'b0;
        next_cycle();
        check_value("automap", automap, after);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (cpuwait && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (cpuwait) begin
            $display("cpuwait did not fall within %0d cycles", wait_limit);
            timeouts++;
        end
    endtask

    // one i/o access held while cpuwait is high
    task automatic port_cycle(input logic [7:0] port, input logic [7:0] data, input logic write);
        bus.a = {8'h00, port};
        bus.a_reg = {8'h00, port};
        bus.d_reg = data;
        bus.ioreq = 1'b1;
        bus.rd = !write;
        bus.wr = write;
        repeat (2) next_cycle();
        saw_wait = cpuwait;
        wait_idle();
        rdata = d_out;
        active = d_out_active;
        bus.ioreq = 1'b0;
        bus.rd = 1'b0;
        bus.wr = 1'b0;
        next_cycle();
    endtask

    function automatic logic mask_rule(input logic [15:0] addr, input logic [3:0] pg);
        return addr < 16'h2000 || (addr < 16'h4000 && pg == 4'd3);
    endfunction

    initial begin
        logic [15:0] addrs [5];
        addrs = '{16'h0000, 16'h1FFF, 16'h2000, 16'h3FFF, 16'h4000};
        bus = '0;
        rst_n = 1'b0;
        en = 1'b1;
        en_hooks = 1'b1;
        en_zc = 1'b0;
        sd_cd = 1'b0;
        rammap = 1'b0;
        magic_mode = 1'b0;
        magic_map = 1'b0;
        repeat (16) @(posedge clk28);
        #2 rst_n = 1'b1;
        next_cycle();
        check_value("sd_cs", sd_cs, 1'b1);
        check_value("page", page, 4'h0);
        check_value("automap", automap, 1'b0);
        check_value("d_out_active", d_out_active, 1'b0);
        check_value("cpuwait", cpuwait, 1'b1);
        wait_idle();

        run_fetch(addr_rst38, 1'b0, 1'b1);
        run_fetch(16'h1FF8, 1'b1, 1'b0);
        magic_mode = 1'b1;
        run_fetch(addr_nmi, 1'b0, 1'b0);
        magic_mode = 1'b0;
        en_hooks = 1'b0;
        run_fetch(addr_rst38, 1'b0, 1'b0);
        en_hooks = 1'b1;
        rammap = 1'b1;
        run_fetch(addr_tape_load, 1'b0, 1'b0);
        rammap = 1'b0;

        // tr-dos area maps while m1 is still high
        bus.a = 16'h3D2F;
        bus.a_reg = 16'h3D2F;
        bus.m1 = 1'b1;
        bus.memreq = 1'b1;
        next_cycle();
        check_value("automap", automap, 1'b1);
        run_fetch(16'h1FF8, 1'b1, 1'b0);

        port_cycle(port_e3, 8'h85, 1'b1);
        check_value("page", page, 4'h5);
        check_value("map", map, 1'b1);
        bus.a = 16'h2000;
        next_cycle();
        check_value("ram", ram, 1'b1);
        bus.a = 16'h0000;
        next_cycle();
        check_value("ram", ram, 1'b0);
        port_cycle(port_e3, 8'h40, 1'b1);
        run_fetch(addr_rst8, 1'b0, 1'b1);
        for (int pg = 3; pg >= 2; pg--) begin
            port_cycle(port_e3, 8'(pg), 1'b1);   // mapram stays set with bit 6 clear
            foreach (addrs[i]) begin
                bus.a = addrs[i];
                next_cycle();
                check_value("ramwr_mask", ramwr_mask, mask_rule(addrs[i], 4'(pg)));
                if (addrs[i] < 16'h4000) begin
                    check_value("ram", ram, 1'b1);
                end
            end
        end
        run_fetch(16'h1FF8, 1'b1, 1'b0);

        wr_byte = 8'($random(seed));
        tx_byte = 8'($random(seed));
        port_cycle(port_eb, wr_byte, 1'b1);
        check_value("cpuwait", saw_wait, 1'b1);
        check_value("sd_mosi", rx_byte, wr_byte);
        tx_byte = 8'($random(seed));
        port_cycle(port_eb, 8'h00, 1'b0);
        check_value("d_out", rdata, tx_byte);
        check_value("d_out_active", active, 1'b1);
        en_zc = 1'b1;
        tx_byte = 8'($random(seed));
        port_cycle(port_57, 8'h00, 1'b0);
        check_value("d_out", rdata, tx_byte);
        check_value("d_out_active", active, 1'b1);

        port_cycle(port_e7, 8'h00, 1'b1);
        check_value("sd_cs", sd_cs, 1'b0);
        port_cycle(port_e7, 8'h01, 1'b1);
        check_value("sd_cs", sd_cs, 1'b1);
        foreach (sel_data[i]) begin
            port_cycle(port_77, sel_data[i], 1'b1);
            check_value("sd_cs", sd_cs, sel_cs[i]);
        end
        sd_cd = 1'b1;
        port_cycle(port_77, 8'h00, 1'b0);
        check_value("d_out", rdata, 8'h01);
        sd_cd = 1'b0;
        port_cycle(port_77, 8'h00, 1'b0);
        check_value("d_out", rdata, 8'h00);
        check_value("d_out_active", active, 1'b1);

        en_zc = 1'b0;
        port_cycle(port_77, 8'h00, 1'b1);
        check_value("sd_cs", sd_cs, 1'b0);
        port_cycle(port_57, 8'h00, 1'b0);
        check_value("cpuwait", saw_wait, 1'b0);
        check_value("d_out_active", active, 1'b0);
        port_cycle(port_77, 8'h00, 1'b0);
        check_value("d_out_active", active, 1'b0);

        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d", checks, errors,
                 timeouts, divmmc_top_inst.divmmc_chk_inst.fail_count);
        if (errors == 0 && timeouts == 0 && divmmc_top_inst.divmmc_chk_inst.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/divmmc_pkg.sv
hdl/divmmc_automap.sv
hdl/divmmc_ports.sv
hdl/divmmc_memmap.sv
hdl/divmmc_top.sv
sim/divmmc_chk.sv
sim/divmmc_tb.sv

// File: Bender.yml
package:
  name: divmmc

sources:
  - files:
      - hdl/divmmc_pkg.sv
      - hdl/divmmc_automap.sv
      - hdl/divmmc_ports.sv
      - hdl/divmmc_memmap.sv
      - hdl/divmmc_top.sv
  - target: simulation
    files:
      - sim/divmmc_chk.sv
      - sim/divmmc_tb.sv
